// ==== cache_subsystem.f ====
logic/bus_pkg.sv
logic/cache_cfg_pkg.sv
logic/direct_mapped_cache.sv
logic/separate_caches.sv
logic/memory_arbiter.sv
logic/cache_subsystem.sv
bench/cache_checker.sv
bench/cache_subsystem_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the cache subsystem testbench with Verilator, run it, then scan the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing -Wno-fatal --top-module cache_subsystem_tb \
    -f cache_subsystem.f -o cache_subsystem_sim &&
    ./obj_dir/cache_subsystem_sim > sim.log 2>&1 || { cat sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -q "Verification failed" sim.log && exit 1 || exit 0

// ==== bench/cache_subsystem_tb.sv ====
// testbench for the level-one cache subsystem
// memory model with two wait cycles, stimulus table and the loop that runs it
`timescale 1ns/10ps
`default_nettype none

module cache_subsystem_tb
    import bus_pkg::*;
    import cache_cfg_pkg::*;
();

    localparam int    NAME_W         = 160;
    localparam int    NROWS          = 18;
    localparam int    CYCLES_PER_ROW = 60;
    localparam int    MEM_AW         = 10;     // 4 KB backing memory
    localparam addr_t LINE_SPAN      = addr_t'(NUM_LINES << OFFSET_W);   // same index, next tag

    typedef enum logic [2:0] {OP_READ, OP_WRITE, OP_FLUSH, OP_CLEAR, OP_PAIR} op_t;

    logic  CLK = 1'b0;
    logic  rst_n;
    addr_t iaddr;
    logic  iren;
    word_t irdata;
    logic  ibusy;
    addr_t daddr;
    logic  dren;
    logic  dwen;
    word_t dwdata;
    word_t drdata;
    logic  dbusy;
    logic  iflush;
    logic  iclear;
    logic  dflush;
    logic  dclear;
    logic  iflush_done;
    logic  iclear_done;
    logic  dflush_done;
    logic  dclear_done;
    addr_t mem_addr;
    logic  mem_ren;
    logic  mem_wen;
    word_t mem_wdata;
    word_t mem_rdata = '0;
    logic  mem_busy  = 1'b1;    // memory idles busy and drops it for one cycle per word
    logic  wait_cnt  = 1'b0;

    logic [NAME_W-1:0] i_name;
    logic [NAME_W-1:0] d_name;
    word_t             i_exp;
    word_t             d_exp;
    logic              report;
    int                errors;
    int                checks;

    // stimulus table, one row per test
    logic [NAME_W-1:0] t_name  [NROWS];
    byte               t_port  [NROWS];
    op_t               t_op    [NROWS];
    addr_t             t_addr  [NROWS];
    word_t             t_wdata [NROWS];
    word_t             t_exp   [NROWS];
    int                n_rows  = 0;
    int                cycles  = 0;
    integer            seed    = 32'hbf6c_ff85;
    word_t             mem     [2**MEM_AW];

    always #4 CLK = ~CLK;

    cache_subsystem DUT (.*);

    cache_checker #(.NAME_W(NAME_W)) scoreboard (.*);

    function automatic word_t preload(input addr_t a);
        return a ^ 32'h5a5a_0000;
    endfunction

    task automatic add_row(input logic [NAME_W-1:0] name, input byte port, input op_t op,
                           input addr_t addr, input word_t wdata, input word_t exp_val);
        t_name[n_rows]  = name;
        t_port[n_rows]  = port;
        t_op[n_rows]    = op;
        t_addr[n_rows]  = addr;
        t_wdata[n_rows] = wdata;
        t_exp[n_rows]   = exp_val;
        n_rows++;
    endtask

    task automatic launch(input int r);
        if (t_port[r] == "I") begin
            iaddr  <= t_addr[r];
            i_name <= t_name[r];
            i_exp  <= t_exp[r];
            iren   <= (t_op[r] == OP_READ) || (t_op[r] == OP_PAIR);
            iflush <= (t_op[r] == OP_FLUSH);
            iclear <= (t_op[r] == OP_CLEAR);
        end else begin
            daddr  <= t_addr[r];
            dwdata <= t_wdata[r];
            d_name <= t_name[r];
            d_exp  <= t_exp[r];
            dren   <= (t_op[r] == OP_READ) || (t_op[r] == OP_PAIR);
            dwen   <= (t_op[r] == OP_WRITE);
            dflush <= (t_op[r] == OP_FLUSH);
            dclear <= (t_op[r] == OP_CLEAR);
        end
    endtask

    // sampled just after a rising edge
    function automatic logic finished(input int r);
        if (t_op[r] == OP_FLUSH)
            return (t_port[r] == "I") ? iflush_done : dflush_done;
        if (t_op[r] == OP_CLEAR)
            return (t_port[r] == "I") ? iclear_done : dclear_done;
        return (t_port[r] == "I") ? !ibusy : !dbusy;
    endfunction

    task automatic release_port(input byte port);
        if (port == "I") begin
            iren   <= 1'b0;
            iflush <= 1'b0;
            iclear <= 1'b0;
        end else begin
            dren   <= 1'b0;
            dwen   <= 1'b0;
            dflush <= 1'b0;
            dclear <= 1'b0;
        end
    endtask

    // memory model, two busy cycles then one cycle with the word
    always @(posedge CLK) begin
        if (!mem_busy) begin
            mem_busy <= 1'b1;
            wait_cnt <= 1'b0;
        end else if (mem_ren || mem_wen) begin
            if (wait_cnt) begin
                mem_busy  <= 1'b0;
                mem_rdata <= mem[mem_addr[MEM_AW+1:2]];
                if (mem_wen)
                    mem[mem_addr[MEM_AW+1:2]] <= mem_wdata;
            end
            wait_cnt <= 1'b1;
        end else begin
            wait_cnt <= 1'b0;
        end
    end

    always @(posedge CLK) begin
        if (rst_n) begin
            cycles <= cycles + 1;
            if (cycles >= n_rows * CYCLES_PER_ROW) begin
                $display("timeout: the tests did not finish within %0d cycles", cycles);
                $display("Verification failed");
                $finish;
            end
        end
    end

    initial begin
        int    r;
        bit    pair;
        bit    a_done;
        bit    b_done;
        addr_t a_conf;
        word_t w1;
        word_t w2;
        word_t w3;
        word_t w4;

        rst_n  = 1'b0;
        iaddr  = '0;
        iren   = 1'b0;
        daddr  = '0;
        dren   = 1'b0;
        dwen   = 1'b0;
        dwdata = '0;
        iflush = 1'b0;
        iclear = 1'b0;
        dflush = 1'b0;
        dclear = 1'b0;
        i_name = '0;
        d_name = '0;
        i_exp  = '0;
        d_exp  = '0;
        report = 1'b0;
        for (int i = 0; i < 2**MEM_AW; i++)
            mem[i] = preload(addr_t'(i) << 2);

        w1     = $random(seed);
        w2     = $random(seed);
        w3     = $random(seed);
        w4     = $random(seed);
        a_conf = 32'h300;
        add_row("cold_iread",    "I", OP_READ,  32'h100, '0, preload(32'h100));
        add_row("iread_hit",     "I", OP_READ,  32'h100, '0, preload(32'h100));
        add_row("dwrite",        "D", OP_WRITE, 32'h210, w1, '0);
        add_row("dread_back",    "D", OP_READ,  32'h210, '0, w1);
        add_row("evict_write",   "D", OP_WRITE, a_conf,  w2, '0);
        add_row("conflict_read", "D", OP_READ,  a_conf + LINE_SPAN, '0,
                preload(a_conf + LINE_SPAN));
        add_row("evict_reread",  "D", OP_READ,  a_conf,  '0, w2);
        add_row("stale_fetch",   "I", OP_READ,  32'h404, '0, preload(32'h404));
        add_row("flush_write",   "D", OP_WRITE, 32'h404, w3, '0);
        add_row("dflush",        "D", OP_FLUSH, '0,      '0, '0);
        add_row("fetch_flushed", "I", OP_READ,  32'h404, '0, w3);
        add_row("clear_write",   "D", OP_WRITE, 32'h508, w4, '0);
        add_row("dclear",        "D", OP_CLEAR, '0,      '0, '0);
        add_row("read_cleared",  "D", OP_READ,  32'h508, '0, preload(32'h508));
        add_row("contend_i",     "I", OP_PAIR,  32'h600, '0, preload(32'h600));    // with next row
        add_row("contend_d",     "D", OP_READ,  32'h704, '0, preload(32'h704));
        add_row("iflush",        "I", OP_FLUSH, '0,      '0, '0);
        add_row("iclear",        "I", OP_CLEAR, '0,      '0, '0);

        repeat (16) @(posedge CLK);
        rst_n <= 1'b1;
        @(posedge CLK);

        r = 0;
        while (r < n_rows) begin
            pair   = (t_op[r] == OP_PAIR);
            a_done = 1'b0;
            b_done = !pair;
            launch(r);
            if (pair)
                launch(r + 1);
            while (!(a_done && b_done)) begin
                @(posedge CLK);
                if (!a_done && finished(r)) begin
                    release_port(t_port[r]);
                    a_done = 1'b1;
                end
                if (!b_done && finished(r + 1)) begin
                    release_port(t_port[r + 1]);
                    b_done = 1'b1;
                end
            end
            @(posedge CLK);
            r += pair ? 2 : 1;
        end

        report <= 1'b1;
        repeat (2) @(posedge CLK);
        if (checks != n_rows)
            $display("checker saw %0d finished tests, the table holds %0d", checks, n_rows);
        if (errors == 0 && checks == n_rows)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/cache_checker.sv ====
// result checker for the cache subsystem testbench
// compares finished reads with the expected words, logs each test and the totals
`timescale 1ns/10ps
`default_nettype none

module cache_checker
    import bus_pkg::*;
#(
    parameter int NAME_W = 160
) (
    input  logic              CLK,
    input  logic              rst_n,
    input  logic              iren,
    input  logic              ibusy,
    input  word_t             irdata,
    input  logic              dren,
    input  logic              dwen,
    input  logic              dbusy,
    input  word_t             drdata,
    input  logic              iflush_done,
    input  logic              iclear_done,
    input  logic              dflush_done,
    input  logic              dclear_done,
    input  logic [NAME_W-1:0] i_name,
    input  logic [NAME_W-1:0] d_name,
    input  word_t             i_exp,
    input  word_t             d_exp,
    input  logic              report,
    output int                errors,
    output int                checks
);

    int passes   = 0;
    int fails    = 0;
    bit reported = 1'b0;

    assign errors = fails;
    assign checks = passes + fails;

    task automatic compare(input logic [NAME_W-1:0] name, input word_t exp_val, input word_t act);
        if (act === exp_val) begin
            passes++;
            $display("pass  %0s: read %h", name, act);
        end else begin
            fails++;
            $display("error %0s: expected %h, actual %h", name, exp_val, act);
        end
    endtask

    task automatic note(input logic [NAME_W-1:0] name, input string what);
        passes++;
        $display("pass  %0s: %0s", name, what);
    endtask

    // a request is finished on the edge where busy is seen low
    always @(posedge CLK) begin
        if (rst_n) begin
            if (iren && !ibusy)
                compare(i_name, i_exp, irdata);
            if (dren && !dbusy)
                compare(d_name, d_exp, drdata);
            if (dwen && !dbusy)
                note(d_name, "write accepted");
            if (iflush_done)
                note(i_name, "flush done");
            if (iclear_done)
                note(i_name, "clear done");
            if (dflush_done)
                note(d_name, "flush done, icache invalidated");
            if (dclear_done)
                note(d_name, "clear done");
            if (report && !reported) begin
                reported = 1'b1;
                $display("%0d tests, %0d passed, %0d failed", passes + fails, passes, fails);
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/cache_subsystem.sv ====
// level-one cache subsystem
// split instruction/data caches in front of one shared memory bus
`timescale 1ns/10ps
`default_nettype none

module cache_subsystem
    import bus_pkg::*;
(
    input  logic  CLK,
    input  logic  rst_n,
    input  addr_t iaddr,
    input  logic  iren,
    output word_t irdata,
    output logic  ibusy,
    input  addr_t daddr,
    input  logic  dren,
    input  logic  dwen,
    input  word_t dwdata,
    output word_t drdata,
    output logic  dbusy,
    input  logic  iflush,
    input  logic  iclear,
    input  logic  dflush,
    input  logic  dclear,
    output logic  iflush_done,
    output logic  iclear_done,
    output logic  dflush_done,
    output logic  dclear_done,
    output addr_t mem_addr,
    output logic  mem_ren,
    output logic  mem_wen,
    output word_t mem_wdata,
    input  word_t mem_rdata,
    input  logic  mem_busy
);

    // per-cache memory ports between the caches and the arbiter
    addr_t imem_addr;
    logic  imem_ren;
    logic  imem_wen;
    word_t imem_wdata;
    word_t imem_rdata;
    logic  imem_busy;
    addr_t dmem_addr;
    logic  dmem_ren;
    logic  dmem_wen;
    word_t dmem_wdata;
    word_t dmem_rdata;
    logic  dmem_busy;

    // each cache runs its own cache_state_t FSM
    separate_caches caches (
        .CLK(CLK), .rst_n(rst_n),
        .iaddr(iaddr), .iren(iren), .irdata(irdata), .ibusy(ibusy),
        .daddr(daddr), .dren(dren), .dwen(dwen), .dwdata(dwdata),
        .drdata(drdata), .dbusy(dbusy),
        .iflush(iflush), .iclear(iclear), .dflush(dflush), .dclear(dclear),
        .iflush_done(iflush_done), .iclear_done(iclear_done),
        .dflush_done(dflush_done), .dclear_done(dclear_done),
        .imem_addr(imem_addr), .imem_ren(imem_ren), .imem_wen(imem_wen),
        .imem_wdata(imem_wdata), .imem_rdata(imem_rdata), .imem_busy(imem_busy),
        .dmem_addr(dmem_addr), .dmem_ren(dmem_ren), .dmem_wen(dmem_wen),
        .dmem_wdata(dmem_wdata), .dmem_rdata(dmem_rdata), .dmem_busy(dmem_busy)
    );

    memory_arbiter arbiter (
        .CLK(CLK), .rst_n(rst_n),
        .imem_addr(imem_addr), .imem_ren(imem_ren), .imem_wen(imem_wen),
        .imem_wdata(imem_wdata), .imem_rdata(imem_rdata), .imem_busy(imem_busy),
        .dmem_addr(dmem_addr), .dmem_ren(dmem_ren), .dmem_wen(dmem_wen),
        .dmem_wdata(dmem_wdata), .dmem_rdata(dmem_rdata), .dmem_busy(dmem_busy),
        .mem_addr(mem_addr), .mem_ren(mem_ren), .mem_wen(mem_wen),
        .mem_wdata(mem_wdata), .mem_rdata(mem_rdata), .mem_busy(mem_busy)
    );

endmodule

`default_nettype wire

// ==== logic/memory_arbiter.sv ====
// memory arbiter
// shares one memory bus between the icache and dcache memory ports,
// data side first, owner held until the memory drops busy
`timescale 1ns/10ps
`default_nettype none

module memory_arbiter
    import bus_pkg::*;
(
    input  logic  CLK,
    input  logic  rst_n,
    input  addr_t imem_addr,
    input  logic  imem_ren,
    input  logic  imem_wen,
    input  word_t imem_wdata,
    output word_t imem_rdata,
    output logic  imem_busy,
    input  addr_t dmem_addr,
    input  logic  dmem_ren,
    input  logic  dmem_wen,
    input  word_t dmem_wdata,
    output word_t dmem_rdata,
    output logic  dmem_busy,
    output addr_t mem_addr,
    output logic  mem_ren,
    output logic  mem_wen,
    output word_t mem_wdata,
    input  word_t mem_rdata,
    input  logic  mem_busy
);

    owner_t owner;
    owner_t grant;
    logic   ireq;
    logic   dreq;

    assign ireq = imem_ren | imem_wen;
    assign dreq = dmem_ren | dmem_wen;

    // a held owner keeps the bus, otherwise the dcache goes first
    always_comb begin
        if (owner != OWN_NONE)
            grant = owner;
        else if (dreq)
            grant = OWN_DCACHE;
        else if (ireq)
            grant = OWN_ICACHE;
        else
            grant = OWN_NONE;
    end

    always_ff @(posedge CLK, negedge rst_n) begin
        if (!rst_n)
            owner <= OWN_NONE;
        else if ((grant != OWN_NONE) && mem_busy)
            owner <= grant;
        else
            owner <= OWN_NONE;          // transfer done or bus idle
    end

    always_comb begin
        mem_addr  = '0;
        mem_ren   = 1'b0;
        mem_wen   = 1'b0;
        mem_wdata = '0;
        case (grant)
            OWN_DCACHE: begin
                mem_addr  = dmem_addr;
                mem_ren   = dmem_ren;
                mem_wen   = dmem_wen;
                mem_wdata = dmem_wdata;
            end
            OWN_ICACHE: begin
                mem_addr  = imem_addr;
                mem_ren   = imem_ren;
                mem_wen   = imem_wen;
                mem_wdata = imem_wdata;
            end
            default: ;
        endcase
    end

    // the waiting side just sees busy
    assign imem_busy  = (grant == OWN_ICACHE) ? mem_busy : ireq;
    assign dmem_busy  = (grant == OWN_DCACHE) ? mem_busy : dreq;
    assign imem_rdata = mem_rdata;
    assign dmem_rdata = mem_rdata;

endmodule

`default_nettype wire

// ==== logic/separate_caches.sv ====
// split instruction and data caches
// two direct-mapped caches side by side; a data flush also invalidates
// the instruction cache so fetches see the written-back words
`timescale 1ns/10ps
`default_nettype none

module separate_caches
    import bus_pkg::*;
(
    input  logic  CLK,
    input  logic  rst_n,
    input  addr_t iaddr,
    input  logic  iren,
    output word_t irdata,
    output logic  ibusy,
    input  addr_t daddr,
    input  logic  dren,
    input  logic  dwen,
    input  word_t dwdata,
    output word_t drdata,
    output logic  dbusy,
    input  logic  iflush,
    input  logic  iclear,
    input  logic  dflush,
    input  logic  dclear,
    output logic  iflush_done,
    output logic  iclear_done,
    output logic  dflush_done,
    output logic  dclear_done,
    output addr_t imem_addr,
    output logic  imem_ren,
    output logic  imem_wen,
    output word_t imem_wdata,
    input  word_t imem_rdata,
    input  logic  imem_busy,
    output addr_t dmem_addr,
    output logic  dmem_ren,
    output logic  dmem_wen,
    output word_t dmem_wdata,
    input  word_t dmem_rdata,
    input  logic  dmem_busy
);

    logic inval_pend;       // dcache flushed, icache invalidate still owed
    logic ic_clear;
    logic ic_clear_done;
    logic dc_flush;
    logic dc_flush_done;

    assign ic_clear    = iclear | inval_pend;
    assign dc_flush    = dflush & ~inval_pend;  // keeps the held command from restarting
    assign iclear_done = ic_clear_done & iclear;
    assign dflush_done = ic_clear_done & inval_pend;

    always_ff @(posedge CLK, negedge rst_n) begin
        if (!rst_n)
            inval_pend <= 1'b0;
        else if (inval_pend && ic_clear_done)
            inval_pend <= 1'b0;
        else if (dc_flush_done)
            inval_pend <= 1'b1;
    end

    direct_mapped_cache icache (
        .CLK(CLK), .rst_n(rst_n),
        .addr(iaddr), .ren(iren),
        .wen(1'b0), .wdata('0),     // fetch port never writes
        .rdata(irdata), .busy(ibusy),
        .flush(iflush), .clear(ic_clear),
        .flush_done(iflush_done), .clear_done(ic_clear_done),
        .mem_addr(imem_addr), .mem_ren(imem_ren), .mem_wen(imem_wen),
        .mem_wdata(imem_wdata), .mem_rdata(imem_rdata), .mem_busy(imem_busy)
    );

    direct_mapped_cache dcache (
        .CLK(CLK), .rst_n(rst_n),
        .addr(daddr), .ren(dren), .wen(dwen), .wdata(dwdata),
        .rdata(drdata), .busy(dbusy),
        .flush(dc_flush), .clear(dclear),
        .flush_done(dc_flush_done), .clear_done(dclear_done),
        .mem_addr(dmem_addr), .mem_ren(dmem_ren), .mem_wen(dmem_wen),
        .mem_wdata(dmem_wdata), .mem_rdata(dmem_rdata), .mem_busy(dmem_busy)
    );

endmodule

`default_nettype wire

// ==== logic/direct_mapped_cache.sv ====
// direct-mapped write-back cache
// one word per block; misses evict a dirty victim and refill the word,
// flush writes back every dirty line, clear drops all lines
`timescale 1ns/10ps
`default_nettype none

module direct_mapped_cache
    import bus_pkg::*;
    import cache_cfg_pkg::*;
(
    input  logic  CLK,
    input  logic  rst_n,
    input  addr_t addr,
    input  logic  ren,
    input  logic  wen,
    input  word_t wdata,
    output word_t rdata,
    output logic  busy,
    input  logic  flush,
    input  logic  clear,
    output logic  flush_done,
    output logic  clear_done,
    output addr_t mem_addr,
    output logic  mem_ren,
    output logic  mem_wen,
    output word_t mem_wdata,
    input  word_t mem_rdata,
    input  logic  mem_busy
);

    cache_state_t state;

    logic [NUM_LINES-1:0] valid;
    logic [NUM_LINES-1:0] dirty;
    logic [TAG_W-1:0]     tag_mem  [NUM_LINES];
    word_t                data_mem [NUM_LINES];

    logic [TAG_W-1:0]   req_tag;
    logic [INDEX_W-1:0] req_idx;
    logic [INDEX_W-1:0] scan_idx;
    logic               hit;
    logic               victim_dirty;
    logic               ack;            // request finished, busy drops for one cycle
    logic               fill_we;
    word_t              fill_data;
    logic               scan_advance;
    logic               scan_last;
    word_t              rdata_r;

    assign req_tag      = addr[ADDR_W-1 -: TAG_W];
    assign req_idx      = addr[OFFSET_W +: INDEX_W];
    assign hit          = valid[req_idx] && (tag_mem[req_idx] == req_tag);
    assign victim_dirty = valid[req_idx] && dirty[req_idx];

    // processor side holds its request until it sees busy low
    assign busy  = (ren | wen) & ~ack;
    assign rdata = rdata_r;

    // write hit, or refill finishing (a write miss merges its word here)
    assign fill_we   = ((state == LOOKUP) && hit && wen) || ((state == REFILL) && !mem_busy);
    assign fill_data = wen ? wdata : mem_rdata;

    // flush moves on after a clean line or a finished writeback
    assign scan_advance = ((state == FLUSH_SCAN) && !(valid[scan_idx] && dirty[scan_idx]))
                       || ((state == FLUSH_WB) && !mem_busy);
    assign scan_last    = (scan_idx == INDEX_W'(NUM_LINES - 1));

    always_comb begin
        mem_ren   = 1'b0;
        mem_wen   = 1'b0;
        mem_addr  = {req_tag, req_idx, {OFFSET_W{1'b0}}};      // refill address
        mem_wdata = data_mem[req_idx];
        case (state)
            WRITEBACK: begin
                mem_wen  = 1'b1;
                mem_addr = {tag_mem[req_idx], req_idx, {OFFSET_W{1'b0}}};
            end
            REFILL: begin
                mem_ren = 1'b1;
            end
            FLUSH_WB: begin
                mem_wen   = 1'b1;
                mem_addr  = {tag_mem[scan_idx], scan_idx, {OFFSET_W{1'b0}}};
                mem_wdata = data_mem[scan_idx];
            end
            default: ;
        endcase
    end

    always_ff @(posedge CLK, negedge rst_n) begin
        if (!rst_n) begin
            state      <= IDLE;
            valid      <= '0;
            dirty      <= '0;
            scan_idx   <= '0;
            ack        <= 1'b0;
            flush_done <= 1'b0;
            clear_done <= 1'b0;
        end else begin
            ack        <= 1'b0;     // all three are single-cycle pulses
            flush_done <= 1'b0;
            clear_done <= 1'b0;
            case (state)
                IDLE: begin
                    if (ren | wen) begin
                        if (!ack)
                            state <= LOOKUP;
                    end else if (flush && !flush_done) begin
                        scan_idx <= '0;
                        state    <= FLUSH_SCAN;
                    end else if (clear && !clear_done) begin
                        state <= CLEARING;
                    end
                end
                LOOKUP: begin
                    if (hit) begin
                        if (wen)
                            dirty[req_idx] <= 1'b1;
                        ack   <= 1'b1;
                        state <= IDLE;
                    end else if (victim_dirty) begin
                        state <= WRITEBACK;
                    end else begin
                        state <= REFILL;
                    end
                end
                WRITEBACK: begin
                    if (!mem_busy)
                        state <= REFILL;
                end
                REFILL: begin
                    if (!mem_busy) begin
                        valid[req_idx] <= 1'b1;
                        dirty[req_idx] <= wen;  // merged write leaves the line dirty
                        ack            <= 1'b1;
                        state          <= IDLE;
                    end
                end
                FLUSH_SCAN: begin
                    if (valid[scan_idx] && dirty[scan_idx])
                        state <= FLUSH_WB;
                end
                FLUSH_WB: ;                     // left by the scan step below
                CLEARING: begin
                    valid      <= '0;
                    dirty      <= '0;
                    clear_done <= 1'b1;
                    state      <= IDLE;
                end
                default: state <= IDLE;
            endcase
            if (scan_advance) begin
                valid[scan_idx] <= 1'b0;    // invalidate as the scan passes
                dirty[scan_idx] <= 1'b0;
                if (scan_last) begin
                    flush_done <= 1'b1;
                    state      <= IDLE;
                end else begin
                    scan_idx <= scan_idx + 1'b1;
                    state    <= FLUSH_SCAN;
                end
            end
        end
    end

    // tag/data arrays and the read register
    always_ff @(posedge CLK) begin
        if (fill_we) begin
            tag_mem[req_idx]  <= req_tag;
            data_mem[req_idx] <= fill_data;
        end
        if ((state == LOOKUP) && hit)
            rdata_r <= data_mem[req_idx];
        else if ((state == REFILL) && !mem_busy)
            rdata_r <= mem_rdata;
    end

endmodule

`default_nettype wire

// ==== logic/cache_cfg_pkg.sv ====
// cache configuration package
// geometry of the direct-mapped, one word per block caches and the
// states of their controller FSM
`default_nettype none

package cache_cfg_pkg;

    localparam int NUM_LINES = 16;
    localparam int INDEX_W   = 4;      // log2 of NUM_LINES
    localparam int OFFSET_W  = 2;      // byte offset inside a word
    localparam int TAG_W     = 26;     // ADDR_W - INDEX_W - OFFSET_W

    typedef enum logic [2:0] {
        IDLE,           // waiting for a request or a command
        LOOKUP,         // tag compare
        WRITEBACK,      // dirty victim out to memory
        REFILL,         // missed word in from memory
        FLUSH_SCAN,     // walk the lines looking for dirty ones
        FLUSH_WB,       // write back the line under the scan index
        CLEARING        // drop all valid and dirty bits
    } cache_state_t;

endpackage

`default_nettype wire

// ==== logic/bus_pkg.sv ====
// bus package
// widths and word types of the processor and memory buses, plus the
// memory arbiter ownership encoding
`default_nettype none

package bus_pkg;

    localparam int ADDR_W = 32;
    localparam int WORD_W = 32;

    // 32-bit byte address
    typedef logic [ADDR_W-1:0] addr_t;
    // 32-bit data word
    typedef logic [WORD_W-1:0] word_t;

    typedef enum logic [1:0] {
        OWN_NONE,               // memory bus free
        OWN_ICACHE,
        OWN_DCACHE
    } owner_t;

endpackage

`default_nettype wire
